// File: source/vga_cfg.svh
`ifndef VGA_CFG_SVH
`define VGA_CFG_SVH

// Colour bits stored for each of red, green and blue
// The adapter is built and checked with 1 and with 2
`define VGA_BITS_PER_CHANNEL 1

// Width of one DAC channel on the video connector
`define VGA_DAC_BITS 10

// Log2 of the screen pixels covered by one stored dot along each axis
// A value of 2 gives 160x120 dots, a value of 1 gives 320x240
`define VGA_DOT_SHIFT 2

// Horizontal timing in pixel clocks, 640x480 at the standard 25 MHz rate
// Sync start and end are both inclusive positions
`define VGA_H_PIXELS 640
`define VGA_H_SYNC_START 659
`define VGA_H_SYNC_END 754
`define VGA_H_TOTAL 800

// Vertical timing in lines
`define VGA_V_PIXELS 480
`define VGA_V_SYNC_START 493
`define VGA_V_SYNC_END 494
`define VGA_V_TOTAL 525

// Stored resolution follows from the visible area and the dot size
`define VGA_X_DOTS (`VGA_H_PIXELS >> `VGA_DOT_SHIFT)
`define VGA_Y_DOTS (`VGA_V_PIXELS >> `VGA_DOT_SHIFT)

`endif

// File: source/vga_pkg.sv
`include "vga_cfg.svh"

package vga_pkg;

	// Number of words in the frame buffer, one per stored dot
	localparam int unsigned fb_words = `VGA_X_DOTS * `VGA_Y_DOTS;

	// Coordinates at the stored resolution
	// The x type is wide enough to carry the scan column past the right edge
	typedef logic [$clog2(`VGA_X_DOTS)-1:0] x_coord_t;
	typedef logic [$clog2(`VGA_Y_DOTS)-1:0] y_coord_t;

	// Linear frame buffer address, 15 bits at 160x120
	typedef logic [$clog2(fb_words)-1:0] fb_addr_t;

	// Packed colour with red on top, then green, then blue
	typedef logic [3*`VGA_BITS_PER_CHANNEL-1:0] pixel_colour_t;

	// One DAC channel
	typedef logic [`VGA_DAC_BITS-1:0] dac_level_t;

	// Where a scan counter is within its line or frame
	typedef enum logic [1:0] {
		active,
		front_porch,
		sync,
		back_porch
	} scan_region_t;

endpackage

// File: source/vga_address_translator.sv
`timescale 1ns/1ps

`include "vga_cfg.svh"

module vga_address_translator (
	input  vga_pkg::x_coord_t x,
	input  vga_pkg::y_coord_t y,
	output vga_pkg::fb_addr_t address
);

	import vga_pkg::*;

	// Row length of the frame buffer in words
	localparam int unsigned x_dots = `VGA_X_DOTS;

	// Running sum of the shifted copies of y
	fb_addr_t row_base;

	// The row base is y times the row length
	// Each set bit of the row length adds one shifted copy of y, so 160 gives
	// (y << 7) + (y << 5) and 320 gives (y << 8) + (y << 6)
	// The loop bound is a constant, so this unrolls into a small adder tree
	always_comb
	begin
		row_base = '0;
		for (int i = 0; i < $bits(fb_addr_t); i++)
		begin
			if (x_dots[i])
			begin
				row_base = row_base + (fb_addr_t'(y) << i);
			end
		end
	end

	// Column offset within the row
	// Scan positions beyond the right edge may map past the last word, the
	// controller blanks those pixels so the read value is never shown
	assign address = row_base + fb_addr_t'(x);

endmodule

// File: source/vga_frame_buffer.sv
`timescale 1ns/1ps

module vga_frame_buffer (
	input  logic                   vga_clock,
	input  logic                   write_enable,
	input  vga_pkg::fb_addr_t      write_address,
	input  vga_pkg::pixel_colour_t write_colour,
	input  vga_pkg::fb_addr_t      read_address,
	output vga_pkg::pixel_colour_t read_colour
);

	import vga_pkg::*;

	// One colour word for each stored dot
	// Sized exactly to the dot count so the tools infer a block RAM
	pixel_colour_t memory [fb_words];

	// Plot port
	// The host writes one dot per strobe, the address was range checked
	// in the top level before it got here
	always_ff @(posedge vga_clock)
	begin
		if (write_enable)
		begin
			memory[write_address] <= write_colour;
		end
	end

	// Scan port
	// Registered read, so the colour for an address shows up one clock later
	// A read on the edge after a write to the same word sees the new colour
	always_ff @(posedge vga_clock)
	begin
		read_colour <= memory[read_address];
	end

	// A write may only land on an existing word
	// The top level gating is what guarantees this
	write_address_in_range: assert property (
		@(posedge vga_clock)
		write_enable |-> (int'(write_address) < fb_words)
	)
	else
		$error("frame buffer write to address %0d outside %0d words",
			write_address, fb_words);

endmodule

// File: source/vga_controller.sv
`timescale 1ns/1ps

`include "vga_cfg.svh"

module vga_controller (
	input  logic                   vga_clock,
	input  logic                   resetn,
	input  vga_pkg::pixel_colour_t read_colour,
	output vga_pkg::x_coord_t      scan_x,
	output vga_pkg::y_coord_t      scan_y,
	output vga_pkg::dac_level_t    vga_r,
	output vga_pkg::dac_level_t    vga_g,
	output vga_pkg::dac_level_t    vga_b,
	output logic                   vga_hs,
	output logic                   vga_vs,
	output logic                   vga_blank
);

	import vga_pkg::*;

	// Counter widths cover the full line and frame including the porches
	localparam int unsigned h_count_w = $clog2(`VGA_H_TOTAL);
	localparam int unsigned v_count_w = $clog2(`VGA_V_TOTAL);
	localparam int unsigned bpc = `VGA_BITS_PER_CHANNEL;

	// Screen position in pixels and lines
	logic [h_count_w-1:0] h_count;
	logic [v_count_w-1:0] v_count;
	logic                 h_last;
	logic                 v_last;

	// Region of the current position on each axis
	scan_region_t h_region;
	scan_region_t v_region;

	// Regions one clock later, in step with the frame buffer read data
	scan_region_t h_region_d;
	scan_region_t v_region_d;
	logic         active_d;

	// Sort a counter value into the four parts of a line or frame
	// Sync bounds are inclusive at both ends
	function automatic scan_region_t decode_region(
		input int unsigned count,
		input int unsigned pixels,
		input int unsigned sync_start,
		input int unsigned sync_end
	);
		scan_region_t region;
		if (count < pixels)
			region = active;
		else if (count < sync_start)
			region = front_porch;
		else if (count <= sync_end)
			region = sync;
		else
			region = back_porch;
		return region;
	endfunction

	// Spread the bits of one channel over the whole DAC word, MSB first
	// With two bits, 2'b10 becomes 10'b1010101010 and full scale stays full scale
	function automatic dac_level_t expand_channel(input logic [bpc-1:0] channel);
		dac_level_t level;
		for (int i = 0; i < $bits(dac_level_t); i++)
		begin
			level[$bits(dac_level_t)-1-i] = channel[bpc-1-(i % bpc)];
		end
		return level;
	endfunction

	assign h_last = (h_count == h_count_w'(`VGA_H_TOTAL - 1));
	assign v_last = (v_count == v_count_w'(`VGA_V_TOTAL - 1));

	// Pixel counter, wraps at the end of each line
	always_ff @(posedge vga_clock or negedge resetn)
	begin
		if (!resetn)
			h_count <= '0;
		else if (h_last)
			h_count <= '0;
		else
			h_count <= h_count + 1'b1;
	end

	// Line counter, steps once per line and wraps at the end of the frame
	always_ff @(posedge vga_clock or negedge resetn)
	begin
		if (!resetn)
			v_count <= '0;
		else if (h_last)
		begin
			if (v_last)
				v_count <= '0;
			else
				v_count <= v_count + 1'b1;
		end
	end

	// Dot coordinate for the frame buffer read
	// Off-screen lines wrap in the narrow y field, those reads are blanked
	assign scan_x = x_coord_t'(h_count >> `VGA_DOT_SHIFT);
	assign scan_y = y_coord_t'(v_count >> `VGA_DOT_SHIFT);

	always_comb
	begin
		h_region = decode_region(h_count, `VGA_H_PIXELS, `VGA_H_SYNC_START, `VGA_H_SYNC_END);
		v_region = decode_region(v_count, `VGA_V_PIXELS, `VGA_V_SYNC_START, `VGA_V_SYNC_END);
	end

	// First stage runs alongside the memory read
	// Porch is a safe reset value, it is neither visible nor in sync, so the
	// outputs stay idle until real decode reaches the second stage
	always_ff @(posedge vga_clock or negedge resetn)
	begin
		if (!resetn)
		begin
			h_region_d <= front_porch;
			v_region_d <= front_porch;
		end
		else
		begin
			h_region_d <= h_region;
			v_region_d <= v_region;
		end
	end

	// Visible only when both axes are in their active part
	assign active_d = (h_region_d == active) && (v_region_d == active);

	// Second stage drives the connector
	// Sync is active low, BLANK is high on visible pixels
	always_ff @(posedge vga_clock or negedge resetn)
	begin
		if (!resetn)
		begin
			vga_hs    <= 1'b1;
			vga_vs    <= 1'b1;
			vga_blank <= 1'b0;
			vga_r     <= '0;
			vga_g     <= '0;
			vga_b     <= '0;
		end
		else
		begin
			vga_hs    <= (h_region_d != sync);
			vga_vs    <= (v_region_d != sync);
			vga_blank <= active_d;
			// Colour is forced to black outside the visible area
			if (active_d)
			begin
				vga_r <= expand_channel(read_colour[3*bpc-1:2*bpc]);
				vga_g <= expand_channel(read_colour[2*bpc-1:bpc]);
				vga_b <= expand_channel(read_colour[bpc-1:0]);
			end
			else
			begin
				vga_r <= '0;
				vga_g <= '0;
				vga_b <= '0;
			end
		end
	end

	// Both counters stay inside one line and one frame
	counters_in_range: assert property (
		@(posedge vga_clock) disable iff (!resetn)
		(h_count < `VGA_H_TOTAL) && (v_count < `VGA_V_TOTAL)
	)
	else
		$error("scan counters out of range h=%0d v=%0d", h_count, v_count);

	// HS low must trace back to a pixel position inside the sync pulse
	// The pin lags the counter by the two pipeline stages
	hs_low_only_in_sync: assert property (
		@(posedge vga_clock) disable iff (!resetn)
		!vga_hs |->
			($past(h_count, 2) >= `VGA_H_SYNC_START) &&
			($past(h_count, 2) <= `VGA_H_SYNC_END)
	)
	else
		$error("HS low outside the horizontal sync region");

endmodule

// File: source/vga_adapter.sv
`timescale 1ns/1ps

`include "vga_cfg.svh"

module vga_adapter (
	input  logic                   vga_clock,
	input  logic                   resetn,
	input  logic                   plot,
	input  vga_pkg::x_coord_t      plot_x,
	input  vga_pkg::y_coord_t      plot_y,
	input  vga_pkg::pixel_colour_t plot_colour,
	output vga_pkg::dac_level_t    vga_r,
	output vga_pkg::dac_level_t    vga_g,
	output vga_pkg::dac_level_t    vga_b,
	output logic                   vga_hs,
	output logic                   vga_vs,
	output logic                   vga_blank
);

	import vga_pkg::*;

	// Plot side
	fb_addr_t      plot_address;
	logic          plot_in_range;
	logic          write_enable;

	// Scan side
	x_coord_t      scan_x;
	y_coord_t      scan_y;
	fb_addr_t      read_address;
	pixel_colour_t read_colour;

	// Dots outside the stored resolution are dropped here
	// Without this an x past the row end would land on the next row
	assign plot_in_range = (plot_x < `VGA_X_DOTS) && (plot_y < `VGA_Y_DOTS);
	assign write_enable  = plot && plot_in_range;

	// Host coordinate to write address, same clock as the strobe
	vga_address_translator plot_translator (
		.x       (plot_x),
		.y       (plot_y),
		.address (plot_address)
	);

	// Scan coordinate to read address
	vga_address_translator scan_translator (
		.x       (scan_x),
		.y       (scan_y),
		.address (read_address)
	);

	vga_frame_buffer frame_buffer (
		.vga_clock     (vga_clock),
		.write_enable  (write_enable),
		.write_address (plot_address),
		.write_colour  (plot_colour),
		.read_address  (read_address),
		.read_colour   (read_colour)
	);

	// Timing, decode and colour output, two clocks behind the scan counters
	vga_controller controller (
		.vga_clock   (vga_clock),
		.resetn      (resetn),
		.read_colour (read_colour),
		.scan_x      (scan_x),
		.scan_y      (scan_y),
		.vga_r       (vga_r),
		.vga_g       (vga_g),
		.vga_b       (vga_b),
		.vga_hs      (vga_hs),
		.vga_vs      (vga_vs),
		.vga_blank   (vga_blank)
	);

endmodule

// File: sim/vga_adapter_tb.sv
`timescale 1ns/1ps

module vga_adapter_tb;

	import vga_pkg::*;

	// 640x480 timing in pixel clocks and lines
	localparam int h_total = 800;
	localparam int v_total = 525;
	localparam int frame_cycles = h_total * v_total;
	// Two frames are checked after reset, a third frame is slack
	localparam int timeout_cycles = 3 * frame_cycles;
	localparam int x_dots = 160;
	localparam int y_dots = 120;
	localparam int max_stim = 32;

	// Test numbers, one pixel test per stimulus entry follows t_pixel
	localparam int t_reset = 0;
	localparam int t_hsync = 1;
	localparam int t_vsync = 2;
	localparam int t_blank = 3;
	localparam int t_range = 4;
	localparam int t_pixel = 5;

	logic          vga_clock = 1'b0;
	logic          resetn = 1'b0;
	logic          plot;
	x_coord_t      plot_x;
	y_coord_t      plot_y;
	pixel_colour_t plot_colour;
	dac_level_t    vga_r;
	dac_level_t    vga_g;
	dac_level_t    vga_b;
	logic          vga_hs;
	logic          vga_vs;
	logic          vga_blank;

	// Stimulus table, one row per line of the data file
	int n_stim = 0;
	int stim_x [max_stim];
	int stim_y [max_stim];
	int stim_colour [max_stim];
	int exp_r [max_stim];
	int exp_g [max_stim];
	int exp_b [max_stim];
	int pixel_checks [max_stim];
	// Stimulus entry shown at each stored dot, -1 where nothing was plotted
	int dot_entry [x_dots * y_dots];

	string test_name [t_pixel + max_stim];
	int    test_errors [t_pixel + max_stim];
	int    tests_done = 0;
	int    tests_failed = 0;
	int    checks_failed = 0;

	// Screen position whose outputs are on the pins, negative before the first
	int          cur_pos = -3;
	int          neg_count = 0;
	int          cycle_count = 0;
	int          hs_low_run = 0;
	logic [29:0] before_first;
	logic [29:0] before_last;
	logic        run_done = 1'b0;

	vga_adapter dut (
		.vga_clock   (vga_clock),
		.resetn      (resetn),
		.plot        (plot),
		.plot_x      (plot_x),
		.plot_y      (plot_y),
		.plot_colour (plot_colour),
		.vga_r       (vga_r),
		.vga_g       (vga_g),
		.vga_b       (vga_b),
		.vga_hs      (vga_hs),
		.vga_vs      (vga_vs),
		.vga_blank   (vga_blank)
	);

	initial
	begin
		forever #10 vga_clock = ~vga_clock;
	end

	function automatic bit in_range(input int e);
		return (stim_x[e] < x_dots) && (stim_y[e] < y_dots);
	endfunction

	task automatic fail_value(input int t, input logic [31:0] expected, input logic [31:0] actual);
		test_errors[t]++;
		$display("Fail %s: expected %h, actual %h at scan position %0d",
			test_name[t], expected, actual, cur_pos);
	endtask

	task automatic finish_test(input int t);
		tests_done++;
		if (test_errors[t] == 0)
			$display("%-14s ok", test_name[t]);
		else
		begin
			tests_failed++;
			$display("%-14s failed with %0d bad checks", test_name[t], test_errors[t]);
		end
	endtask

	// Columns are x, y, colour and the red, green and blue DAC levels, in hex
	task automatic read_stimulus();
		int    fd;
		int    status;
		int    x;
		int    y;
		int    c;
		int    r;
		int    g;
		int    b;
		string line;
		fd = $fopen("sim/vga_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("Error: the stimulus file sim/vga_stimulus.txt could not be opened");
			checks_failed++;
		end
		while (fd != 0 && !$feof(fd))
		begin
			line = "";
			status = $fgets(line, fd);
			// A hash starts a note line
			if (line.len() > 0 && line[0] != "#")
			begin
				status = $sscanf(line, "%h %h %h %h %h %h", x, y, c, r, g, b);
				if (status == 6 && n_stim < max_stim)
				begin
					stim_x[n_stim] = x;
					stim_y[n_stim] = y;
					stim_colour[n_stim] = c;
					exp_r[n_stim] = r;
					exp_g[n_stim] = g;
					exp_b[n_stim] = b;
					n_stim++;
				end
			end
		end
		if (fd != 0)
			$fclose(fd);
	endtask

	// Idle pins while reset holds and before the pipeline fills
	task automatic check_idle();
		assert (vga_hs === 1'b1) else fail_value(t_reset, 1, vga_hs);
		assert (vga_vs === 1'b1) else fail_value(t_reset, 1, vga_vs);
		assert (vga_blank === 1'b0) else fail_value(t_reset, 0, vga_blank);
		assert ({vga_r, vga_g, vga_b} === 30'd0) else fail_value(t_reset, 0, {vga_r, vga_g, vga_b});
	endtask

	task automatic check_position(input int p);
		int          h;
		int          v;
		int          frame;
		int          e;
		logic        exp_hs;
		logic        exp_vs;
		logic        exp_blank;
		logic [29:0] shown;
		h = p % h_total;
		v = (p / h_total) % v_total;
		frame = p / frame_cycles;
		shown = {vga_r, vga_g, vga_b};
		// Sync pulses are active low over inclusive ranges
		exp_hs = !(h >= 659 && h <= 754);
		exp_vs = !(v == 493 || v == 494);
		exp_blank = (h < 640) && (v < 480);
		assert (vga_hs === exp_hs) else fail_value(t_hsync, exp_hs, vga_hs);
		assert (vga_vs === exp_vs) else fail_value(t_vsync, exp_vs, vga_vs);
		assert (vga_blank === exp_blank) else fail_value(t_blank, exp_blank, vga_blank);
		if (!exp_blank)
		begin
			assert (shown === 30'd0) else fail_value(t_blank, 0, shown);
		end
		// HS pulse length in this line, judged at the last pixel
		if (h == 0)
			hs_low_run = 0;
		if (vga_hs === 1'b0)
			hs_low_run++;
		if (h == h_total - 1)
		begin
			assert (hs_low_run == 96) else fail_value(t_hsync, 96, hs_low_run);
		end
		if (exp_blank)
		begin
			// Each stored dot covers a 4x4 block of screen pixels
			e = dot_entry[(v >> 2) * x_dots + (h >> 2)];
			if (frame == 1 && e >= 0)
			begin
				assert (vga_r === dac_level_t'(exp_r[e])) else fail_value(t_pixel + e, exp_r[e], vga_r);
				assert (vga_g === dac_level_t'(exp_g[e])) else fail_value(t_pixel + e, exp_g[e], vga_g);
				assert (vga_b === dac_level_t'(exp_b[e])) else fail_value(t_pixel + e, exp_b[e], vga_b);
				pixel_checks[e]++;
				if (pixel_checks[e] == 16)
					finish_test(t_pixel + e);
			end
			// Dots (0, 1) and (0, 119) are where the first two bad plots would land
			// if the range gate let them through
			if (h == 3 && v == 7 && frame == 0)
				before_first = shown;
			if (h == 3 && v == 479 && frame == 0)
				before_last = shown;
			if (h == 3 && v == 7 && frame == 1)
			begin
				assert (shown === before_first) else fail_value(t_range, before_first, shown);
			end
			if (h == 3 && v == 479 && frame == 1)
			begin
				assert (shown === before_last) else fail_value(t_range, before_last, shown);
				finish_test(t_range);
			end
		end
	endtask

	// Outputs change on the rising edge, so they are read on the falling one
	always @(negedge vga_clock)
	begin
		if (!resetn)
			check_idle();
		else
		begin
			// The first rising edge with reset released loads position 0,
			// and its outputs arrive two edges later
			cur_pos = neg_count - 2;
			neg_count++;
			if (cur_pos < 0)
				check_idle();
			if (cur_pos == -1)
				finish_test(t_reset);
			if (cur_pos >= 0 && cur_pos < 2 * frame_cycles)
				check_position(cur_pos);
			if (cur_pos == 2 * frame_cycles - 1)
				run_done = 1'b1;
		end
	end

	always @(posedge vga_clock)
	begin
		cycle_count++;
		if (cycle_count >= timeout_cycles)
		begin
			$display("Error: the run did not finish within %0d cycles", timeout_cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial
	begin
		plot = 1'b0;
		plot_x = '0;
		plot_y = '0;
		plot_colour = '0;
		foreach (dot_entry[i])
			dot_entry[i] = -1;
		test_name[t_reset] = "reset";
		test_name[t_hsync] = "hsync";
		test_name[t_vsync] = "vsync";
		test_name[t_blank] = "blank";
		test_name[t_range] = "out_of_range";
		read_stimulus();
		for (int e = 0; e < n_stim; e++)
		begin
			if (in_range(e))
			begin
				dot_entry[stim_y[e] * x_dots + stim_x[e]] = e;
				test_name[t_pixel + e] = $sformatf("pixel_%0d_%0d", stim_x[e], stim_y[e]);
			end
		end
		repeat (3) @(posedge vga_clock);
		resetn <= 1'b1;
		// In-range plots go in at the start of the first frame
		for (int e = 0; e < n_stim; e++)
		begin
			if (in_range(e))
			begin
				@(posedge vga_clock);
				plot <= 1'b1;
				plot_x <= x_coord_t'(stim_x[e]);
				plot_y <= y_coord_t'(stim_y[e]);
				plot_colour <= pixel_colour_t'(stim_colour[e]);
			end
		end
		@(posedge vga_clock);
		plot <= 1'b0;
		// Out-of-range plots wait for vertical blanking of the first frame
		wait (cur_pos >= 480 * h_total);
		for (int e = 0; e < n_stim; e++)
		begin
			if (!in_range(e))
			begin
				@(posedge vga_clock);
				plot <= 1'b1;
				plot_x <= x_coord_t'(stim_x[e]);
				plot_y <= y_coord_t'(stim_y[e]);
				plot_colour <= pixel_colour_t'(stim_colour[e]);
			end
		end
		@(posedge vga_clock);
		plot <= 1'b0;
		wait (run_done);
		finish_test(t_hsync);
		finish_test(t_vsync);
		finish_test(t_blank);
		for (int e = 0; e < n_stim; e++)
		begin
			if (in_range(e) && pixel_checks[e] != 16)
			begin
				$display("Error in %s: only %0d of 16 screen pixels were seen",
					test_name[t_pixel + e], pixel_checks[e]);
				test_errors[t_pixel + e]++;
				finish_test(t_pixel + e);
			end
		end
		$display("%0d tests run, %0d failed, %0d other errors", tests_done, tests_failed,
			checks_failed);
		if (tests_failed == 0 && checks_failed == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: sim/vga_stimulus.txt
# x y colour red green blue, all hex, colour is 3 bits red-green-blue
# x >= a0 or y >= 78 is an out-of-range plot, its level columns are unused
0 0 7 3ff 3ff 3ff
9f 77 4 3ff 000 000
1 0 2 000 3ff 000
2 0 1 000 000 3ff
3 0 6 3ff 3ff 000
0 1 1 000 000 3ff
9f 0 3 000 3ff 3ff
0 77 5 3ff 000 3ff
50 3c 6 3ff 3ff 000
4f 3b 1 000 000 3ff
a 14 0 000 000 000
23 45 2 000 3ff 000
64 10 7 3ff 3ff 3ff
7 70 4 3ff 000 000
80 5 6 3ff 3ff 000
9e 77 5 3ff 000 3ff
12 34 3 000 3ff 3ff
# out-of-range plots, the first two would land on dots (0, 1) and (0, 119) without the check
a0 0 0 000 000 000
a0 76 2 000 000 000
ff 77 7 000 000 000
0 78 6 000 000 000
9f 7f 3 000 000 000

// File: vga_adapter.f
+incdir+source
source/vga_pkg.sv
source/vga_address_translator.sv
source/vga_frame_buffer.sv
source/vga_controller.sv
source/vga_adapter.sv
sim/vga_adapter_tb.sv
